/* id_ctrl_assertions.sv */
//--------------------------------------------------------------------------
// concurrent checks on the ID stage controller
//   stall ordering, IR valid shape, fence group size
//   bound into the top level
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module id_ctrl_assertions (
  input  logic                        debug_id_inst_clk,
  input  logic                        cpurst_b,
  input  logic                        pipedown_stall,
  input  logic                        id_stall,
  input  logic                        fence_id_inst_vld,
  input  id_ctrl_pkg::pipedown_cnt_e  pipedown_cnt,
  input  id_ctrl_pkg::ir_vld_t        ir_inst_vld
);

  import id_ctrl_pkg::*;

  // holding the slots always blocks the front end
  stall_order: assert property (
    @(posedge debug_id_inst_clk) disable iff (!cpurst_b)
    pipedown_stall |-> id_stall
  ) else $error("pipedown_stall high while id_stall is low");

  // uops fill the IR stage from slot 0 without gaps
  ir_contiguous: assert property (
    @(posedge debug_id_inst_clk) disable iff (!cpurst_b)
    (ir_inst_vld & (ir_inst_vld + ir_vld_t'(1))) == '0
  ) else $error("ir_inst_vld is not a run from slot 0");

  // a fence in slot 0 travels alone
  fence_alone: assert property (
    @(posedge debug_id_inst_clk) disable iff (!cpurst_b)
    fence_id_inst_vld |-> (pipedown_cnt == pd_one || pipedown_cnt == pd_none)
  ) else $error("fence in slot 0 with a group of two or three");

endmodule

bind id_ctrl_top id_ctrl_assertions i_assertions (
  .debug_id_inst_clk (debug_id_inst_clk),
  .cpurst_b          (cpurst_b),
  .pipedown_stall    (pipedown_stall),
  .id_stall          (id_stall),
  .fence_id_inst_vld (fence_id_inst_vld),
  .pipedown_cnt      (pipedown_cnt),
  .ir_inst_vld       (ir_inst_vld)
);

/* id_ctrl_consts.svh */
//--------------------------------------------------------------------------
// sizing macros for the ID stage controller
//   slot counts of the ID and IR stages
//   width of the per-slot instruction kind code
//--------------------------------------------------------------------------

`ifndef ID_CTRL_CONSTS_SVH
`define ID_CTRL_CONSTS_SVH

// instructions held in the ID stage
`define ID_SLOTS 3

// uop slots in the IR stage
`define IR_SLOTS 4

// kind code from the decode datapath
`define KIND_W 2

`endif

/* id_ctrl_pkg.sv */
//--------------------------------------------------------------------------
// shared types of the ID stage controller
//   instruction kind, pipedown count, ID and IR valid vectors
//--------------------------------------------------------------------------

`include "id_ctrl_consts.svh"

package id_ctrl_pkg;

  // kind of a decoded ID instruction
  // short split expands to two uops, the others to one
  typedef enum logic [`KIND_W-1:0] {
    kind_normal      = 2'd0,
    kind_split_short = 2'd1,
    kind_fence       = 2'd2
  } inst_kind_e;

  // leading ID instructions that leave this cycle
  // value equals the number of instructions
  typedef enum logic [1:0] {
    pd_none  = 2'd0,
    pd_one   = 2'd1,
    pd_two   = 2'd2,
    pd_three = 2'd3
  } pipedown_cnt_e;

  // one bit per ID slot, slot 0 is the oldest
  typedef logic [`ID_SLOTS-1:0] id_vld_t;

  // one bit per IR uop slot
  typedef logic [`IR_SLOTS-1:0] ir_vld_t;

endpackage

/* id_ctrl_tb.sv */
//--------------------------------------------------------------------------
// testbench for the ID stage controller
//   reads per-cycle stimulus and expected counts from the tests file
//   reference model of slot queue, group select, uop issue, debug trace
//   one report line per test, totals at the end
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "id_ctrl_consts.svh"

module id_ctrl_tb;

  import id_ctrl_pkg::*;

  // hex columns of a data line
  localparam int NCOL = 13;

  logic          debug_id_inst_clk;
  logic          cpurst_b;
  id_vld_t       ib_inst_vld;
  logic          flush_fe;
  logic          cancel;
  inst_kind_e    id_inst_kind [`ID_SLOTS];
  logic          fence_stall;
  logic [2:0]    fence_inst_vld;
  logic          ir_stall;
  logic          ir_stage_stall;
  logic          debug_inst_en;
  logic          hpcp_cnt_en;
  id_vld_t       id_inst_vld;
  pipedown_cnt_e pipedown_cnt;
  logic          pipedown_stall;
  logic          id_stall;
  logic          had_pipe_stall;
  logic          fence_id_inst_vld;
  ir_vld_t       ir_inst_vld;
  logic          debug_pipedown;
  logic          hpcp_backend_stall;
  id_vld_t       had_inst_vld;

  // tests file contents
  string       test_names [$];
  int          line_test [$];
  logic [51:0] line_words [$];

  // model state mirroring the DUT registers
  id_vld_t m_vld = '0;
  logic    m_pd = 1'b0;
  id_vld_t m_had = '0;

  int n_tests = 0;
  int n_checks = 0;
  int n_errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int cycle_cnt = 0;
  int cycle_limit = 0;

  id_ctrl_top i_dut (
    .debug_id_inst_clk  (debug_id_inst_clk),
    .cpurst_b           (cpurst_b),
    .ib_inst_vld        (ib_inst_vld),
    .flush_fe           (flush_fe),
    .cancel             (cancel),
    .id_inst_kind       (id_inst_kind),
    .fence_stall        (fence_stall),
    .fence_inst_vld     (fence_inst_vld),
    .ir_stall           (ir_stall),
    .ir_stage_stall     (ir_stage_stall),
    .debug_inst_en      (debug_inst_en),
    .hpcp_cnt_en        (hpcp_cnt_en),
    .id_inst_vld        (id_inst_vld),
    .pipedown_cnt       (pipedown_cnt),
    .pipedown_stall     (pipedown_stall),
    .id_stall           (id_stall),
    .had_pipe_stall     (had_pipe_stall),
    .fence_id_inst_vld  (fence_id_inst_vld),
    .ir_inst_vld        (ir_inst_vld),
    .debug_pipedown     (debug_pipedown),
    .hpcp_backend_stall (hpcp_backend_stall),
    .had_inst_vld       (had_inst_vld)
  );

  // 100 ns period
  initial debug_id_inst_clk = 1'b0;
  always #50 debug_id_inst_clk = ~debug_id_inst_clk;

  // run limit is set once the tests file is read
  always @(posedge debug_id_inst_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  //------------------------------------------------------------------------
  // reference model
  //------------------------------------------------------------------------
  function automatic pipedown_cnt_e model_count(id_vld_t vld, inst_kind_e kind [`ID_SLOTS],
                                                logic fs);
    id_vld_t nrm;
    id_vld_t sht;
    id_vld_t fnc;
    id_vld_t pln;
    int      s01;
    for (int i = 0; i < `ID_SLOTS; i++) begin
      nrm[i] = vld[i] && (kind[i] == kind_normal);
      sht[i] = vld[i] && (kind[i] == kind_split_short);
      fnc[i] = vld[i] && (kind[i] == kind_fence);
    end
    pln = nrm | sht;
    // shorts among the two oldest slots
    s01 = int'(sht[0]) + int'(sht[1]);
    if ((fnc[0] && !fs) || (pln[0] && fnc[1])) begin
      return pd_one;
    end
    // slot 2 blocked by a fence or by more than four uops
    if (pln[0] && pln[1] && (fnc[2] || (pln[2] && (s01 + int'(sht[2])) >= 2))) begin
      return pd_two;
    end
    if ((fnc == '0) && !(sht[2] && s01 > 0) && !(vld[2] && s01 == 2)) begin
      return pd_three;
    end
    return pd_none;
  endfunction

  function automatic ir_vld_t model_ir(id_vld_t vld, inst_kind_e kind [`ID_SLOTS],
                                       pipedown_cnt_e cnt, logic [2:0] fiv);
    int uops = 0;
    // fence unit drives the IR slots itself
    if (vld[0] && kind[0] == kind_fence) begin
      return {1'b0, fiv};
    end
    for (int i = 0; i < int'(cnt); i++) begin
      if (vld[i]) begin
        uops += (kind[i] == kind_split_short) ? 2 : 1;
      end
    end
    return ir_vld_t'((5'd1 << uops) - 5'd1);
  endfunction

  // register update of the model at a rising edge
  task automatic advance_model();
    pipedown_cnt_e cnt;
    logic          hold;
    logic          stall_id;
    id_vld_t       nxt;
    cnt      = model_count(m_vld, id_inst_kind, fence_stall);
    hold     = m_vld[0] && (ir_stall || fence_stall);
    stall_id = m_vld[0] && (ir_stall || cnt != pd_three);
    if (flush_fe || cancel) begin
      nxt = '0;
    end
    else if (hold || cnt == pd_none) begin
      nxt = m_vld;
    end
    else if (cnt == pd_three) begin
      nxt = ib_inst_vld;
    end
    else begin
      nxt = m_vld >> int'(cnt);
    end
    // trace uses the old flag and slots
    m_had = m_pd ? m_vld : '0;
    m_pd  = m_vld[0] && (debug_inst_en || hpcp_cnt_en) && !stall_id;
    m_vld = nxt;
  endtask

  //------------------------------------------------------------------------
  // stimulus and checks
  //------------------------------------------------------------------------
  task automatic apply_line(logic [51:0] w);
    ib_inst_vld     <= w[2:0];
    id_inst_kind[0] <= inst_kind_e'(w[5:4]);
    id_inst_kind[1] <= inst_kind_e'(w[9:8]);
    id_inst_kind[2] <= inst_kind_e'(w[13:12]);
    flush_fe        <= w[16];
    cancel          <= w[20];
    fence_stall     <= w[24];
    fence_inst_vld  <= w[30:28];
    ir_stall        <= w[32];
    ir_stage_stall  <= w[36];
    debug_inst_en   <= w[40];
    hpcp_cnt_en     <= w[44];
  endtask

  task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    test_checks++;
    assert (got === exp) else begin
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic check_outputs(logic [1:0] exp_cnt);
    pipedown_cnt_e cnt;
    cnt = model_count(m_vld, id_inst_kind, fence_stall);
    check_field("id_inst_vld", 32'(id_inst_vld), 32'(m_vld));
    // count comes from the tests file
    check_field("pipedown_cnt", 32'(pipedown_cnt), 32'(exp_cnt));
    check_field("pipedown_stall", 32'(pipedown_stall),
                32'(m_vld[0] && (ir_stall || fence_stall)));
    check_field("id_stall", 32'(id_stall), 32'(m_vld[0] && (ir_stall || cnt != pd_three)));
    check_field("had_pipe_stall", 32'(had_pipe_stall),
                32'((m_vld[0] && fence_stall) || ir_stage_stall));
    check_field("fence_id_inst_vld", 32'(fence_id_inst_vld),
                32'(m_vld[0] && id_inst_kind[0] == kind_fence));
    check_field("ir_inst_vld", 32'(ir_inst_vld),
                32'(model_ir(m_vld, id_inst_kind, cnt, fence_inst_vld)));
    check_field("debug_pipedown", 32'(debug_pipedown), 32'(m_pd));
    check_field("hpcp_backend_stall", 32'(hpcp_backend_stall), 32'(!m_pd));
    check_field("had_inst_vld", 32'(had_inst_vld), 32'(m_had));
  endtask

  task automatic report_test(int idx);
    n_tests++;
    $display("test %s: %0d checks, %0d errors", test_names[idx], test_checks, test_errors);
  endtask

  task automatic read_tests(output bit ok);
    int          fd;
    int          rc;
    string       line;
    string       name;
    int          f [NCOL];
    logic [51:0] w;
    ok = 1'b1;
    fd = $fopen("id_ctrl_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open id_ctrl_tests.txt");
      ok = 1'b0;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;
      end
      // marker line opens a new test
      if (line.substr(0, 3) == "test") begin
        rc = $sscanf(line, "test %s", name);
        test_names.push_back(name);
        continue;
      end
      rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                   f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                   f[7], f[8], f[9], f[10], f[11], f[12]);
      if (rc != NCOL || test_names.size() == 0) begin
        $display("malformed data line in tests file: %s", line);
        ok = 1'b0;
      end
      else begin
        for (int i = 0; i < NCOL; i++) begin
          w[i*4 +: 4] = f[i][3:0];
        end
        line_words.push_back(w);
        line_test.push_back(test_names.size() - 1);
      end
    end
    $fclose(fd);
  endtask

  //------------------------------------------------------------------------
  // main sequence
  //------------------------------------------------------------------------
  initial begin
    bit          file_ok;
    int          cur;
    logic [51:0] w;
    cpurst_b       <= 1'b0;
    ib_inst_vld    <= '0;
    flush_fe       <= 1'b0;
    cancel         <= 1'b0;
    fence_stall    <= 1'b0;
    fence_inst_vld <= '0;
    ir_stall       <= 1'b0;
    ir_stage_stall <= 1'b0;
    debug_inst_en  <= 1'b0;
    hpcp_cnt_en    <= 1'b0;
    for (int i = 0; i < `ID_SLOTS; i++) begin
      id_inst_kind[i] <= kind_normal;
    end
    read_tests(file_ok);
    if (!file_ok || line_words.size() == 0) begin
      $display("tests file missing or unreadable, no test was run");
      $display("Test failed");
      $finish;
    end
    else begin
      cycle_limit = 2 * line_words.size() + 20;
      // five cycles of reset
      repeat (5) @(posedge debug_id_inst_clk);
      cpurst_b <= 1'b1;
      cur = -1;
      for (int n = 0; n < line_words.size(); n++) begin
        if (line_test[n] != cur) begin
          if (cur >= 0) begin
            report_test(cur);
          end
          cur         = line_test[n];
          test_checks = 0;
          test_errors = 0;
        end
        w = line_words[n];
        @(posedge debug_id_inst_clk);
        advance_model();
        apply_line(w);
        // outputs settled by the falling edge
        @(negedge debug_id_inst_clk);
        check_outputs(w[49:48]);
      end
      report_test(cur);
      $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
        $display("Test completed successfully");
      end
      else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

/* id_ctrl_tests.txt */
# ib k0 k1 k2 flush cancel fence_stall fence_vld ir_stall ir_stage_stall dbg_en hpcp_en exp_cnt
# hex per column, kinds 0 normal 1 short 2 fence, one data line per cycle
test reset_idle
0 0 0 0 0 0 0 0 0 0 0 0 3
7 0 0 0 0 0 0 0 0 0 0 0 3
test normal_group
7 0 0 0 0 0 0 0 0 0 0 0 3
test short_mix
0 1 0 1 0 0 0 0 0 0 0 0 2
7 1 0 0 0 0 0 0 0 0 0 0 3
0 1 1 0 0 0 0 0 0 0 0 0 2
7 0 0 0 0 0 0 0 0 0 0 0 3
test fence_stall
0 0 2 0 0 0 0 0 0 0 0 0 1
0 2 0 0 0 0 1 3 0 0 0 0 0
0 2 0 0 0 0 1 3 0 0 0 0 0
0 2 0 0 0 0 0 7 0 0 0 0 1
7 0 0 0 0 0 0 0 0 0 0 0 3
test ir_stall_flush
0 0 0 0 0 0 0 0 1 0 0 0 3
0 0 0 0 0 0 0 0 1 0 0 0 3
0 0 0 0 1 0 0 0 1 0 0 0 3
7 0 0 0 0 0 0 0 0 1 0 0 3
0 0 0 0 0 1 0 0 1 0 0 0 3
test debug_trace
7 0 0 0 0 0 0 0 0 0 1 0 3
7 0 0 0 0 0 0 0 0 0 1 0 3
0 0 0 0 0 0 0 0 0 0 0 1 3
7 0 0 0 0 0 0 0 0 0 0 0 3
0 0 0 0 0 0 0 0 0 0 0 0 3
0 0 0 0 0 0 0 0 0 0 0 0 3

/* id_ctrl_top.sv */
//--------------------------------------------------------------------------
// ID stage controller top level
//   slot valid queue, group select, uop issue and debug trace
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "id_ctrl_consts.svh"

module id_ctrl_top (
  input  logic                        debug_id_inst_clk,
  input  logic                        cpurst_b,
  // instruction buffer side
  input  id_ctrl_pkg::id_vld_t        ib_inst_vld,
  input  logic                        flush_fe,
  input  logic                        cancel,
  // decode datapath kinds
  input  id_ctrl_pkg::inst_kind_e     id_inst_kind [`ID_SLOTS],
  // fence unit
  input  logic                        fence_stall,
  input  logic [2:0]                  fence_inst_vld,
  // IR stage back-pressure
  input  logic                        ir_stall,
  input  logic                        ir_stage_stall,
  // trace enables
  input  logic                        debug_inst_en,
  input  logic                        hpcp_cnt_en,
  // stage state and control
  output id_ctrl_pkg::id_vld_t        id_inst_vld,
  output id_ctrl_pkg::pipedown_cnt_e  pipedown_cnt,
  output logic                        pipedown_stall,
  output logic                        id_stall,
  output logic                        had_pipe_stall,
  output logic                        fence_id_inst_vld,
  // IR stage uop valids
  output id_ctrl_pkg::ir_vld_t        ir_inst_vld,
  // debug and hpcp
  output logic                        debug_pipedown,
  output logic                        hpcp_backend_stall,
  output id_ctrl_pkg::id_vld_t        had_inst_vld
);

  import id_ctrl_pkg::*;

  // slot valid registers
  id_inst_queue i_queue (
    .debug_id_inst_clk (debug_id_inst_clk),
    .cpurst_b          (cpurst_b),
    .ib_inst_vld       (ib_inst_vld),
    .flush_fe          (flush_fe),
    .cancel            (cancel),
    .pipedown_stall    (pipedown_stall),
    .pipedown_cnt      (pipedown_cnt),
    .id_inst_vld       (id_inst_vld)
  );

  // group size and stalls
  id_group_select i_select (
    .id_inst_vld       (id_inst_vld),
    .id_inst_kind      (id_inst_kind),
    .fence_stall       (fence_stall),
    .ir_stall          (ir_stall),
    .ir_stage_stall    (ir_stage_stall),
    .pipedown_cnt      (pipedown_cnt),
    .pipedown_stall    (pipedown_stall),
    .id_stall          (id_stall),
    .had_pipe_stall    (had_pipe_stall),
    .fence_id_inst_vld (fence_id_inst_vld)
  );

  // uop expansion into IR
  id_uop_issue i_issue (
    .id_inst_vld       (id_inst_vld),
    .id_inst_kind      (id_inst_kind),
    .pipedown_cnt      (pipedown_cnt),
    .fence_inst_vld    (fence_inst_vld),
    .ir_inst_vld       (ir_inst_vld)
  );

  // debug and hpcp trace
  id_debug_track i_debug (
    .debug_id_inst_clk  (debug_id_inst_clk),
    .cpurst_b           (cpurst_b),
    .id_inst_vld        (id_inst_vld),
    .id_stall           (id_stall),
    .debug_inst_en      (debug_inst_en),
    .hpcp_cnt_en        (hpcp_cnt_en),
    .debug_pipedown     (debug_pipedown),
    .hpcp_backend_stall (hpcp_backend_stall),
    .had_inst_vld       (had_inst_vld)
  );

endmodule

/* id_debug_track.sv */
//--------------------------------------------------------------------------
// debug and performance counter trace of issued groups
//   pipedown flag for the hpcp backend stall count
//   replay of the traced slot valids to the debug unit
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module id_debug_track (
  input  logic                  debug_id_inst_clk,
  input  logic                  cpurst_b,
  input  id_ctrl_pkg::id_vld_t  id_inst_vld,
  input  logic                  id_stall,
  // trace enables from debug unit and hpcp
  input  logic                  debug_inst_en,
  input  logic                  hpcp_cnt_en,
  output logic                  debug_pipedown,
  output logic                  hpcp_backend_stall,
  output id_ctrl_pkg::id_vld_t  had_inst_vld
);

  import id_ctrl_pkg::*;

  // slot 0 occupied while somebody is watching
  logic    trace_req;
  logic    pipedown_q;
  id_vld_t trace_vld_q;

  assign trace_req = id_inst_vld[0] && (debug_inst_en || hpcp_cnt_en);

  //------------------------------------------------------------------------
  // traced group left ID
  //------------------------------------------------------------------------
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      pipedown_q <= 1'b0;
    end
    else begin
      pipedown_q <= trace_req && !id_stall;
    end
  end

  // slot valids seen while the flag is up, zero otherwise
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      trace_vld_q <= '0;
    end
    else begin
      trace_vld_q <= pipedown_q ? id_inst_vld : '0;
    end
  end

  assign debug_pipedown     = pipedown_q;
  // backend counted as stalled unless a group just went down
  assign hpcp_backend_stall = !pipedown_q;
  assign had_inst_vld       = trace_vld_q;

endmodule

/* id_group_select.sv */
//--------------------------------------------------------------------------
// ID issue group selection
//   per-slot classification into normal, short split and fence
//   pipedown count under the four-uop limit and fence isolation
//   stall outputs to the front end, ID pipeline and debug unit
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "id_ctrl_consts.svh"

module id_group_select (
  input  id_ctrl_pkg::id_vld_t        id_inst_vld,
  // kind per slot, meaningful only where the slot is valid
  input  id_ctrl_pkg::inst_kind_e     id_inst_kind [`ID_SLOTS],
  // fence unit busy with slot 0
  input  logic                        fence_stall,
  input  logic                        ir_stall,
  input  logic                        ir_stage_stall,
  output id_ctrl_pkg::pipedown_cnt_e  pipedown_cnt,
  output logic                        pipedown_stall,
  output logic                        id_stall,
  output logic                        had_pipe_stall,
  output logic                        fence_id_inst_vld
);

  import id_ctrl_pkg::*;

  // qualified kind flags, one bit per slot
  id_vld_t is_normal;
  id_vld_t is_short;
  id_vld_t is_fence;
  // slot may travel together with its neighbours
  id_vld_t is_plain;
  logic    any_fence;
  logic    cnt_one;
  logic    cnt_two;
  logic    cnt_three;

  //------------------------------------------------------------------------
  // slot classification
  //------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < `ID_SLOTS; i++) begin
      is_normal[i] = id_inst_vld[i] && (id_inst_kind[i] == kind_normal);
      is_short[i]  = id_inst_vld[i] && (id_inst_kind[i] == kind_split_short);
      is_fence[i]  = id_inst_vld[i] && (id_inst_kind[i] == kind_fence);
    end
  end

  assign is_plain  = is_normal | is_short;
  assign any_fence = |is_fence;

  //------------------------------------------------------------------------
  // group size conditions
  //------------------------------------------------------------------------
  // lone fence once the fence unit lets it go,
  // or slot 0 alone when slot 1 is a fence
  assign cnt_one = (is_fence[0] && !fence_stall)
                || (is_plain[0] && is_fence[1]);

  // slots 0 and 1 go, slot 2 is held back by a fence or by uop overflow
  assign cnt_two = is_plain[0] && is_plain[1]
                && (is_fence[2]
                 || (is_short[2] && (is_short[0] || is_short[1]))
                 || (is_normal[2] && is_short[0] && is_short[1]));

  // whole stage fits in four uops and holds no fence
  // also true for an empty stage
  assign cnt_three = !any_fence
                  && !(is_short[2] && (is_short[0] || is_short[1]))
                  && !(id_inst_vld[2] && is_short[0] && is_short[1]);

  always_comb begin
    if (cnt_one) begin
      pipedown_cnt = pd_one;
    end
    else if (cnt_two) begin
      // two before three
      pipedown_cnt = pd_two;
    end
    else if (cnt_three) begin
      pipedown_cnt = pd_three;
    end
    else begin
      pipedown_cnt = pd_none;
    end
  end

  //------------------------------------------------------------------------
  // stalls
  //------------------------------------------------------------------------
  // ID pipeline holds its slots
  assign pipedown_stall = id_inst_vld[0] && (ir_stall || fence_stall);

  // front end may not refill ID
  assign id_stall = id_inst_vld[0] && (ir_stall || (pipedown_cnt != pd_three));

  // debug unit view of a stuck pipe
  assign had_pipe_stall = (id_inst_vld[0] && fence_stall) || ir_stage_stall;

  // fence unit only takes a fence from slot 0
  assign fence_id_inst_vld = is_fence[0];

endmodule

/* id_inst_queue.sv */
//--------------------------------------------------------------------------
// ID slot valid registers
//   refill from the instruction buffer on a full pipedown
//   shift down by the number of issued instructions otherwise
//   cleared by front-end flush or cancel
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module id_inst_queue (
  input  logic                        debug_id_inst_clk,
  input  logic                        cpurst_b,
  // valids offered by the instruction buffer
  input  id_ctrl_pkg::id_vld_t        ib_inst_vld,
  input  logic                        flush_fe,
  input  logic                        cancel,
  // from the group select logic
  input  logic                        pipedown_stall,
  input  id_ctrl_pkg::pipedown_cnt_e  pipedown_cnt,
  output id_ctrl_pkg::id_vld_t        id_inst_vld
);

  import id_ctrl_pkg::*;

  // current slot contents
  id_vld_t slot_vld_q;
  // contents after this cycle's pipedown
  id_vld_t slot_vld_nxt;

  //------------------------------------------------------------------------
  // next slot contents
  //------------------------------------------------------------------------
  always_comb begin
    case (pipedown_cnt)
      // slot 0 leaves, slots 1 and 2 move down
      pd_one: begin
        slot_vld_nxt = slot_vld_q >> 1;
      end
      // slots 0 and 1 leave, slot 2 becomes slot 0
      pd_two: begin
        slot_vld_nxt = slot_vld_q >> 2;
      end
      // whole group gone or stage empty, take a new group
      pd_three: begin
        slot_vld_nxt = ib_inst_vld;
      end
      // nothing leaves
      default: begin
        slot_vld_nxt = slot_vld_q;
      end
    endcase
  end

  //------------------------------------------------------------------------
  // slot valid registers
  //------------------------------------------------------------------------
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      slot_vld_q <= '0;
    end
    else if (flush_fe || cancel) begin
      // flush wins over any stall
      slot_vld_q <= '0;
    end
    else if (!pipedown_stall) begin
      slot_vld_q <= slot_vld_nxt;
    end
    // stalled, hold the slots
  end

  assign id_inst_vld = slot_vld_q;

endmodule

/* id_uop_issue.sv */
//--------------------------------------------------------------------------
// IR slot valid generation
//   expands the chosen ID group into uop slots
//   short split takes two slots, fence uops come from the fence unit
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "id_ctrl_consts.svh"

module id_uop_issue (
  input  id_ctrl_pkg::id_vld_t        id_inst_vld,
  input  id_ctrl_pkg::inst_kind_e     id_inst_kind [`ID_SLOTS],
  input  id_ctrl_pkg::pipedown_cnt_e  pipedown_cnt,
  // fence unit uop valids for IR slots 0 to 2
  input  logic [2:0]                  fence_inst_vld,
  output id_ctrl_pkg::ir_vld_t        ir_inst_vld
);

  import id_ctrl_pkg::*;

  // wide enough to count up to IR_SLOTS uops
  localparam int UOP_W = $clog2(`IR_SLOTS + 1);

  logic             slot0_fence;
  logic [UOP_W-1:0] uop_total;

  assign slot0_fence = id_inst_vld[0] && (id_inst_kind[0] == kind_fence);

  //------------------------------------------------------------------------
  // uop count of the leaving group
  //------------------------------------------------------------------------
  always_comb begin
    uop_total = '0;
    for (int i = 0; i < `ID_SLOTS; i++) begin
      // only slots inside the group, and only valid ones
      if ((i < int'(pipedown_cnt)) && id_inst_vld[i]) begin
        if (id_inst_kind[i] == kind_split_short) begin
          uop_total = uop_total + UOP_W'(2);
        end
        else begin
          uop_total = uop_total + UOP_W'(1);
        end
      end
    end
  end

  //------------------------------------------------------------------------
  // IR valid vector
  //------------------------------------------------------------------------
  always_comb begin
    if (slot0_fence) begin
      // fence owns the IR stage, last slot stays empty
      ir_inst_vld = ir_vld_t'(fence_inst_vld);
    end
    else begin
      // contiguous run of uop_total slots from slot 0
      for (int j = 0; j < `IR_SLOTS; j++) begin
        ir_inst_vld[j] = (j < int'(uop_total));
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# build and run the ID stage controller testbench with Verilator
# a build error or an aborted run also marks the log as failed

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module id_ctrl_tb -o id_ctrl_sim \
  && ./obj_dir/id_ctrl_sim > sim.log 2>&1 \
  || echo "Test failed" >> sim.log
cat sim.log
grep -q "Test failed" sim.log && exit 1
exit 0

/* tb.f */
+incdir+.
id_ctrl_pkg.sv
id_inst_queue.sv
id_group_select.sv
id_uop_issue.sv
id_debug_track.sv
id_ctrl_top.sv
id_ctrl_assertions.sv
id_ctrl_tb.sv
